// ==== design/rp_pkg.sv ====
// rp_pkg: shared widths, sample types, bus region map and register offsets
package rp_pkg;

  //////////////////////////////////////////////////////////////////////
  // data path
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned CHN       = 2;   // analog channels
  localparam int unsigned DWS       = 14;  // sample width
  localparam int unsigned DWM       = 16;  // gain width
  localparam int unsigned CAL_SHIFT = 14;  // gain 1.0 == 2**14

  typedef logic signed [DWS-1:0] sample_t;  // two's complement sample
  typedef logic signed [DWM-1:0] gain_t;    // fixed point gain
  typedef logic        [DWS-1:0] raw_t;     // neg-slope pin word

  localparam gain_t GAIN_UNITY = 16'sd16384;

  // PDM outputs
  localparam int unsigned PDM_CHN = 4;
  localparam int unsigned PDM_DWC = 8;
  typedef logic [PDM_DWC-1:0] pdm_lvl_t;

  localparam int unsigned LED_W = 8;

  //////////////////////////////////////////////////////////////////////
  // system bus
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned BUS_AW     = 32;
  localparam int unsigned BUS_DW     = 32;
  localparam int unsigned REGIONS    = 8;
  localparam int unsigned REGION_W   = 3;   // addr[22:20]
  localparam int unsigned REGION_LSB = 20;
  localparam int unsigned REG_HK     = 0;
  localparam int unsigned REG_AMS    = 4;
  // regions with a real slave behind them
  localparam logic [REGIONS-1:0] REGION_LIVE = (8'h01 << REG_HK) | (8'h01 << REG_AMS);

  // housekeeping word offsets
  localparam logic [7:0] HK_LOOP     = 8'h00;
  localparam logic [7:0] HK_LED      = 8'h04;
  localparam logic [7:0] HK_ADC_MUL0 = 8'h10;
  localparam logic [7:0] HK_ADC_MUL1 = 8'h14;
  localparam logic [7:0] HK_ADC_SUM0 = 8'h18;
  localparam logic [7:0] HK_ADC_SUM1 = 8'h1C;
  localparam logic [7:0] HK_DAC_MUL0 = 8'h20;
  localparam logic [7:0] HK_DAC_MUL1 = 8'h24;
  localparam logic [7:0] HK_DAC_SUM0 = 8'h28;
  localparam logic [7:0] HK_DAC_SUM1 = 8'h2C;

  // ams: pdm level n at AMS_PDM0 + 4*n
  localparam logic [7:0] AMS_PDM0 = 8'h00;

endpackage

// ==== design/sys_bus_decoder.sv ====
// sys_bus_decoder: splits the system bus into 8 regions, muxes back the responses
`timescale 1ns/1ps

module sys_bus_decoder (
  input  logic [rp_pkg::BUS_AW-1:0]                      sys_addr_i,
  input  logic                                           sys_wen_i,
  input  logic                                           sys_ren_i,
  input  logic [rp_pkg::REGIONS-1:0][rp_pkg::BUS_DW-1:0] reg_rdata_i,
  input  logic [rp_pkg::REGIONS-1:0]                     reg_ack_i,
  input  logic [rp_pkg::REGIONS-1:0]                     reg_err_i,
  output logic [rp_pkg::REGIONS-1:0]                     reg_wen_o,
  output logic [rp_pkg::REGIONS-1:0]                     reg_ren_o,
  output logic [rp_pkg::BUS_DW-1:0]                      sys_rdata_o,
  output logic                                           sys_ack_o,
  output logic                                           sys_err_o
);

  logic [rp_pkg::REGION_W-1:0]                   sel;        // region number
  logic [rp_pkg::REGIONS-1:0]                    cs;         // one-hot select
  logic [rp_pkg::REGIONS-1:0][rp_pkg::BUS_DW-1:0] rdata_all;
  logic [rp_pkg::REGIONS-1:0]                    ack_all;
  logic [rp_pkg::REGIONS-1:0]                    err_all;

  assign sel = sys_addr_i[rp_pkg::REGION_LSB +: rp_pkg::REGION_W];
  assign cs  = rp_pkg::REGIONS'(1) << sel;

  // strobes only reach the addressed region
  assign reg_wen_o = cs & {rp_pkg::REGIONS{sys_wen_i}};
  assign reg_ren_o = cs & {rp_pkg::REGIONS{sys_ren_i}};

  //////////////////////////////////////////////////////////////////////
  // response per region
  //////////////////////////////////////////////////////////////////////

  // empty regions answer in the request cycle, with zero data
  always_comb
  begin
    for (int r = 0; r < rp_pkg::REGIONS; r++)
    begin
      if (rp_pkg::REGION_LIVE[r])
      begin
        rdata_all[r] = reg_rdata_i[r];
        ack_all[r]   = reg_ack_i[r];
        err_all[r]   = reg_err_i[r];
      end
      else
      begin
        rdata_all[r] = '0;
        ack_all[r]   = reg_wen_o[r] | reg_ren_o[r];  // immediate ack
        err_all[r]   = 1'b0;
      end
    end
  end

  assign sys_rdata_o = rdata_all[sel];    // address held until ack
  assign sys_ack_o   = |(cs & ack_all);
  assign sys_err_o   = |(cs & err_all);

endmodule

// ==== design/hk_regs.sv ====
// hk_regs: housekeeping registers for loopback, ADC/DAC calibration and LEDs
`timescale 1ns/1ps

module hk_regs (
  input  logic                         adc_clk,
  input  logic                         frstn,
  input  logic [rp_pkg::BUS_AW-1:0]    sys_addr_i,
  input  logic [rp_pkg::BUS_DW-1:0]    sys_wdata_i,
  input  logic                         sys_wen_i,
  input  logic                         sys_ren_i,
  output logic [rp_pkg::BUS_DW-1:0]    sys_rdata_o,
  output logic                         sys_ack_o,
  output logic                         sys_err_o,
  output logic                         digital_loop_o,
  output rp_pkg::gain_t                adc_mul_o [rp_pkg::CHN],
  output rp_pkg::sample_t              adc_sum_o [rp_pkg::CHN],
  output rp_pkg::gain_t                dac_mul_o [rp_pkg::CHN],
  output rp_pkg::sample_t              dac_sum_o [rp_pkg::CHN],
  output logic [rp_pkg::LED_W-1:0]     led_o
);

  logic [rp_pkg::BUS_DW-1:0] rdata_mux;

  //////////////////////////////////////////////////////////////////////
  // register writes
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk or negedge frstn)
  begin
    if (!frstn)
    begin
      digital_loop_o <= 1'b0;
      led_o          <= '0;
      for (int ch = 0; ch < rp_pkg::CHN; ch++)
      begin
        adc_mul_o[ch] <= rp_pkg::GAIN_UNITY;  // unity gain, no offset
        adc_sum_o[ch] <= '0;
        dac_mul_o[ch] <= rp_pkg::GAIN_UNITY;
        dac_sum_o[ch] <= '0;
      end
    end
    else if (sys_wen_i)
    begin
      case (sys_addr_i[7:0])  // word offset inside the region
        rp_pkg::HK_LOOP:     digital_loop_o <= sys_wdata_i[0];
        rp_pkg::HK_LED:      led_o          <= sys_wdata_i[rp_pkg::LED_W-1:0];
        rp_pkg::HK_ADC_MUL0: adc_mul_o[0]   <= sys_wdata_i[rp_pkg::DWM-1:0];
        rp_pkg::HK_ADC_MUL1: adc_mul_o[1]   <= sys_wdata_i[rp_pkg::DWM-1:0];
        rp_pkg::HK_ADC_SUM0: adc_sum_o[0]   <= sys_wdata_i[rp_pkg::DWS-1:0];
        rp_pkg::HK_ADC_SUM1: adc_sum_o[1]   <= sys_wdata_i[rp_pkg::DWS-1:0];
        rp_pkg::HK_DAC_MUL0: dac_mul_o[0]   <= sys_wdata_i[rp_pkg::DWM-1:0];
        rp_pkg::HK_DAC_MUL1: dac_mul_o[1]   <= sys_wdata_i[rp_pkg::DWM-1:0];
        rp_pkg::HK_DAC_SUM0: dac_sum_o[0]   <= sys_wdata_i[rp_pkg::DWS-1:0];
        rp_pkg::HK_DAC_SUM1: dac_sum_o[1]   <= sys_wdata_i[rp_pkg::DWS-1:0];
        default: ;  // unknown offsets ignored
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // readback, zero extended
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    rdata_mux = '0;
    case (sys_addr_i[7:0])
      rp_pkg::HK_LOOP:     rdata_mux[0]                 = digital_loop_o;
      rp_pkg::HK_LED:      rdata_mux[rp_pkg::LED_W-1:0] = led_o;
      rp_pkg::HK_ADC_MUL0: rdata_mux[rp_pkg::DWM-1:0]   = adc_mul_o[0];
      rp_pkg::HK_ADC_MUL1: rdata_mux[rp_pkg::DWM-1:0]   = adc_mul_o[1];
      rp_pkg::HK_ADC_SUM0: rdata_mux[rp_pkg::DWS-1:0]   = adc_sum_o[0];
      rp_pkg::HK_ADC_SUM1: rdata_mux[rp_pkg::DWS-1:0]   = adc_sum_o[1];
      rp_pkg::HK_DAC_MUL0: rdata_mux[rp_pkg::DWM-1:0]   = dac_mul_o[0];
      rp_pkg::HK_DAC_MUL1: rdata_mux[rp_pkg::DWM-1:0]   = dac_mul_o[1];
      rp_pkg::HK_DAC_SUM0: rdata_mux[rp_pkg::DWS-1:0]   = dac_sum_o[0];
      rp_pkg::HK_DAC_SUM1: rdata_mux[rp_pkg::DWS-1:0]   = dac_sum_o[1];
      default: ;                                        // reads as 0
    endcase
  end

  always_ff @(posedge adc_clk)
  begin
    if (sys_ren_i)
      sys_rdata_o <= rdata_mux;  // valid together with ack
  end

  // ack one cycle after any strobe
  always_ff @(posedge adc_clk or negedge frstn)
  begin
    if (!frstn)
      sys_ack_o <= 1'b0;
    else
      sys_ack_o <= sys_wen_i | sys_ren_i;
  end

  assign sys_err_o = 1'b0;

endmodule

// ==== design/lin_cal.sv ====
// lin_cal: two-stage gain, offset and saturation for one sample stream
`timescale 1ns/1ps

module lin_cal (
  input  logic            adc_clk,
  input  logic            frstn,
  input  rp_pkg::sample_t dat_i,
  input  rp_pkg::gain_t   mul_i,
  input  rp_pkg::sample_t sum_i,
  output rp_pkg::sample_t dat_o
);

  localparam int unsigned PW = rp_pkg::DWS + rp_pkg::DWM;  // full product

  logic signed [PW-1:0]         mul_q;   // stage 1
  logic signed [rp_pkg::DWM-1:0] scaled;  // product >>> CAL_SHIFT
  logic signed [rp_pkg::DWM:0]   acc;     // one guard bit for the offset
  logic                          ovf;

  // stage 1: multiply
  always_ff @(posedge adc_clk or negedge frstn)
  begin
    if (!frstn)
      mul_q <= '0;
    else
      mul_q <= dat_i * mul_i;
  end

  // drop the fraction, sign kept by the slice
  assign scaled = mul_q[rp_pkg::CAL_SHIFT +: rp_pkg::DWM];
  assign acc    = {scaled[rp_pkg::DWM-1], scaled}
                + {{(rp_pkg::DWM+1-rp_pkg::DWS){sum_i[rp_pkg::DWS-1]}}, sum_i};

  // fits only if every bit above the sample sign matches it
  assign ovf = (acc[rp_pkg::DWM:rp_pkg::DWS-1] != {(rp_pkg::DWM-rp_pkg::DWS+2){acc[rp_pkg::DWM]}});

  // stage 2: offset and saturate
  always_ff @(posedge adc_clk or negedge frstn)
  begin
    if (!frstn)
      dat_o <= '0;
    else if (ovf)
      dat_o <= {acc[rp_pkg::DWM], {(rp_pkg::DWS-1){~acc[rp_pkg::DWM]}}};  // rail
    else
      dat_o <= acc[rp_pkg::DWS-1:0];
  end

endmodule

// ==== design/analog_path.sv ====
// analog_path: ADC capture, loopback, DAC mixing, calibration and DAC conversion
`timescale 1ns/1ps

module analog_path (
  input  logic            adc_clk,
  input  logic            frstn,
  input  rp_pkg::raw_t    adc_dat_i      [rp_pkg::CHN],
  input  rp_pkg::sample_t asg_dat_i      [rp_pkg::CHN],
  input  rp_pkg::sample_t pid_dat_i      [rp_pkg::CHN],
  input  logic            digital_loop_i,
  input  rp_pkg::gain_t   adc_mul_i      [rp_pkg::CHN],
  input  rp_pkg::sample_t adc_sum_i      [rp_pkg::CHN],
  input  rp_pkg::gain_t   dac_mul_i      [rp_pkg::CHN],
  input  rp_pkg::sample_t dac_sum_i      [rp_pkg::CHN],
  output rp_pkg::sample_t adc_dat_o      [rp_pkg::CHN],
  output rp_pkg::raw_t    dac_dat_o      [rp_pkg::CHN]
);

  localparam int unsigned W = rp_pkg::DWS;

  for (genvar ch = 0; ch < rp_pkg::CHN; ch++)
  begin : g_ch

    rp_pkg::sample_t adc_cap;    // captured, two's complement
    rp_pkg::sample_t adc_mux;    // pins or loopback
    logic signed [W:0] dac_sum;  // one extra bit for the sum
    rp_pkg::sample_t dac_sat;
    rp_pkg::sample_t dac_cal;
    rp_pkg::sample_t dac_out;    // output register, signed

    ////////////////////////////////////////////////////////////////////
    // ADC side
    ////////////////////////////////////////////////////////////////////

    // neg slope -> two's complement: keep msb, flip the rest
    always_ff @(posedge adc_clk or negedge frstn)
    begin
      if (!frstn)
        adc_cap <= '0;
      else
        adc_cap <= {adc_dat_i[ch][W-1], ~adc_dat_i[ch][W-2:0]};
    end

    assign adc_mux = digital_loop_i ? dac_cal : adc_cap;  // loop skips pins

    lin_cal u_adc_cal (
      .adc_clk (adc_clk),
      .frstn   (frstn),
      .dat_i   (adc_mux),
      .mul_i   (adc_mul_i[ch]),
      .sum_i   (adc_sum_i[ch]),
      .dat_o   (adc_dat_o[ch])
    );

    ////////////////////////////////////////////////////////////////////
    // DAC side
    ////////////////////////////////////////////////////////////////////

    // generator + controller, then clamp
    assign dac_sum = {asg_dat_i[ch][W-1], asg_dat_i[ch]}
                   + {pid_dat_i[ch][W-1], pid_dat_i[ch]};
    assign dac_sat = (dac_sum[W] ^ dac_sum[W-1]) ?
                     {dac_sum[W], {(W-1){~dac_sum[W]}}} : dac_sum[W-1:0];

    lin_cal u_dac_cal (
      .adc_clk (adc_clk),
      .frstn   (frstn),
      .dat_i   (dac_sat),
      .mul_i   (dac_mul_i[ch]),
      .sum_i   (dac_sum_i[ch]),
      .dat_o   (dac_cal)
    );

    always_ff @(posedge adc_clk or negedge frstn)
    begin
      if (!frstn)
        dac_out <= '0;  // pins show 0x1fff
      else
        dac_out <= dac_cal;
    end

    // back to neg slope
    assign dac_dat_o[ch] = {dac_out[W-1], ~dac_out[W-2:0]};

  end

endmodule

// ==== design/ams_pdm.sv ====
// ams_pdm: PDM level registers and one first-order modulator per output
`timescale 1ns/1ps

module ams_pdm (
  input  logic                         adc_clk,
  input  logic                         frstn,
  input  logic [rp_pkg::BUS_AW-1:0]    sys_addr_i,
  input  logic [rp_pkg::BUS_DW-1:0]    sys_wdata_i,
  input  logic                         sys_wen_i,
  input  logic                         sys_ren_i,
  output logic [rp_pkg::BUS_DW-1:0]    sys_rdata_o,
  output logic                         sys_ack_o,
  output logic                         sys_err_o,
  output logic [rp_pkg::PDM_CHN-1:0]   pdm_o
);

  rp_pkg::pdm_lvl_t lvl [rp_pkg::PDM_CHN];  // density per output
  rp_pkg::pdm_lvl_t acc [rp_pkg::PDM_CHN];
  logic             hit;                    // offset inside the level block
  logic [1:0]       idx;
  logic [rp_pkg::BUS_DW-1:0] rdata_mux;

  assign hit = (sys_addr_i[7:4] == rp_pkg::AMS_PDM0[7:4]);
  assign idx = sys_addr_i[3:2];

  //////////////////////////////////////////////////////////////////////
  // bus side
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk or negedge frstn)
  begin
    if (!frstn)
    begin
      for (int ch = 0; ch < rp_pkg::PDM_CHN; ch++)
        lvl[ch] <= '0;
      sys_ack_o <= 1'b0;
    end
    else
    begin
      if (sys_wen_i && hit)
        lvl[idx] <= sys_wdata_i[rp_pkg::PDM_DWC-1:0];
      sys_ack_o <= sys_wen_i | sys_ren_i;  // one cycle later
    end
  end

  always_comb
  begin
    rdata_mux = '0;
    if (hit)
      rdata_mux[rp_pkg::PDM_DWC-1:0] = lvl[idx];
  end

  always_ff @(posedge adc_clk)
  begin
    if (sys_ren_i)
      sys_rdata_o <= rdata_mux;
  end

  assign sys_err_o = 1'b0;

  //////////////////////////////////////////////////////////////////////
  // modulators, range fixed at 256
  //////////////////////////////////////////////////////////////////////

  // carry out of an 8-bit accumulator gives level ones per 256 cycles
  always_ff @(posedge adc_clk or negedge frstn)
  begin
    if (!frstn)
    begin
      for (int ch = 0; ch < rp_pkg::PDM_CHN; ch++)
        acc[ch] <= '0;
      pdm_o <= '0;
    end
    else
    begin
      for (int ch = 0; ch < rp_pkg::PDM_CHN; ch++)
        {pdm_o[ch], acc[ch]} <= {1'b0, acc[ch]} + {1'b0, lvl[ch]};
    end
  end

endmodule

// ==== design/rp_analog_top.sv ====
// rp_analog_top: analog front end with bus decoder, register blocks and data path
`timescale 1ns/1ps

module rp_analog_top (
  input  logic                          adc_clk,
  input  logic                          frstn,
  input  rp_pkg::raw_t                  adc_dat_i [rp_pkg::CHN],
  input  rp_pkg::sample_t               asg_dat_i [rp_pkg::CHN],  // generator stream
  input  rp_pkg::sample_t               pid_dat_i [rp_pkg::CHN],  // controller stream
  output rp_pkg::sample_t               adc_dat_o [rp_pkg::CHN],
  output rp_pkg::raw_t                  dac_dat_o [rp_pkg::CHN],
  input  logic [rp_pkg::BUS_AW-1:0]     sys_addr_i,
  input  logic [rp_pkg::BUS_DW-1:0]     sys_wdata_i,
  input  logic                          sys_wen_i,
  input  logic                          sys_ren_i,
  output logic [rp_pkg::BUS_DW-1:0]     sys_rdata_o,
  output logic                          sys_err_o,
  output logic                          sys_ack_o,
  output logic [rp_pkg::LED_W-1:0]      led_o,
  output logic [rp_pkg::PDM_CHN-1:0]    pdm_o
);

  logic [rp_pkg::REGIONS-1:0] reg_wen;  // per region strobes
  logic [rp_pkg::REGIONS-1:0] reg_ren;
  logic [rp_pkg::BUS_DW-1:0]  hk_rdata, ams_rdata;
  logic                       hk_ack, ams_ack;
  logic                       hk_err, ams_err;

  // calibration and loopback
  logic            digital_loop;
  rp_pkg::gain_t   adc_mul [rp_pkg::CHN];
  rp_pkg::sample_t adc_sum [rp_pkg::CHN];
  rp_pkg::gain_t   dac_mul [rp_pkg::CHN];
  rp_pkg::sample_t dac_sum [rp_pkg::CHN];

  //////////////////////////////////////////////////////////////////////
  // control and status
  //////////////////////////////////////////////////////////////////////

  // region 0 hk, region 4 ams, the rest are answered by the decoder
  sys_bus_decoder u_dec (
    .sys_addr_i  (sys_addr_i),
    .sys_wen_i   (sys_wen_i),
    .sys_ren_i   (sys_ren_i),
    .reg_rdata_i ({{(3*rp_pkg::BUS_DW){1'b0}}, ams_rdata, {(3*rp_pkg::BUS_DW){1'b0}}, hk_rdata}),
    .reg_ack_i   ({3'b000, ams_ack, 3'b000, hk_ack}),
    .reg_err_i   ({3'b000, ams_err, 3'b000, hk_err}),
    .reg_wen_o   (reg_wen),
    .reg_ren_o   (reg_ren),
    .sys_rdata_o (sys_rdata_o),
    .sys_ack_o   (sys_ack_o),
    .sys_err_o   (sys_err_o)
  );

  hk_regs u_hk (
    .adc_clk        (adc_clk),
    .frstn          (frstn),
    .sys_addr_i     (sys_addr_i),
    .sys_wdata_i    (sys_wdata_i),
    .sys_wen_i      (reg_wen[rp_pkg::REG_HK]),
    .sys_ren_i      (reg_ren[rp_pkg::REG_HK]),
    .sys_rdata_o    (hk_rdata),
    .sys_ack_o      (hk_ack),
    .sys_err_o      (hk_err),
    .digital_loop_o (digital_loop),
    .adc_mul_o      (adc_mul),
    .adc_sum_o      (adc_sum),
    .dac_mul_o      (dac_mul),
    .dac_sum_o      (dac_sum),
    .led_o          (led_o)
  );

  ams_pdm u_ams (
    .adc_clk     (adc_clk),
    .frstn       (frstn),
    .sys_addr_i  (sys_addr_i),
    .sys_wdata_i (sys_wdata_i),
    .sys_wen_i   (reg_wen[rp_pkg::REG_AMS]),
    .sys_ren_i   (reg_ren[rp_pkg::REG_AMS]),
    .sys_rdata_o (ams_rdata),
    .sys_ack_o   (ams_ack),
    .sys_err_o   (ams_err),
    .pdm_o       (pdm_o)
  );

  //////////////////////////////////////////////////////////////////////
  // data path
  //////////////////////////////////////////////////////////////////////

  analog_path u_path (
    .adc_clk        (adc_clk),
    .frstn          (frstn),
    .adc_dat_i      (adc_dat_i),
    .asg_dat_i      (asg_dat_i),
    .pid_dat_i      (pid_dat_i),
    .digital_loop_i (digital_loop),
    .adc_mul_i      (adc_mul),
    .adc_sum_i      (adc_sum),
    .dac_mul_i      (dac_mul),
    .dac_sum_i      (dac_sum),
    .adc_dat_o      (adc_dat_o),
    .dac_dat_o      (dac_dat_o)
  );

endmodule

// ==== dv/rp_analog_properties.sv ====
// rp_analog_properties: system bus protocol checks bound into the top level
`timescale 1ns/1ps

module rp_analog_properties (
  input logic adc_clk,
  input logic frstn,
  input logic wen_i,
  input logic ren_i,
  input logic ack_i,
  input logic err_i
);

  logic req;  // any strobe this cycle

  assign req = wen_i | ren_i;

  // no slave ever flags an error
  err_low: assert property (@(posedge adc_clk) disable iff (!frstn) !err_i)
    else $error("bus error flag raised");

  // unused regions answer at once, live ones a cycle later
  ack_in_time: assert property (@(posedge adc_clk) disable iff (!frstn)
    (req && !ack_i) |=> ack_i)
    else $error("request not acknowledged within one cycle");

  ack_has_req: assert property (@(posedge adc_clk) disable iff (!frstn)
    ack_i |-> (req || $past(req)))  // stray ack
    else $error("acknowledge without a request in this or the previous cycle");

endmodule

bind rp_analog_top rp_analog_properties u_props (
  .adc_clk (adc_clk),
  .frstn   (frstn),
  .wen_i   (sys_wen_i),
  .ren_i   (sys_ren_i),
  .ack_i   (sys_ack_o),
  .err_i   (sys_err_o)
);

// ==== dv/tb_rp_analog.sv ====
// tb_rp_analog testbench for bus registers, ADC/DAC data path, loopback and PDM
`timescale 1ns/1ps

module tb_rp_analog;

  parameter int unsigned SEED = 32'h12f8;

  localparam int CLK_HALF    = 5;    // 10 ns period
  localparam int ACK_TIMEOUT = 8;    // cycles
  localparam int N_SAMP      = 40;   // samples per data row
  localparam int BUS_CYC     = 4;    // worst case per access with idle
  localparam int SMAX        = 2**(rp_pkg::DWS-1) - 1;
  localparam int SMIN        = -(2**(rp_pkg::DWS-1));

  typedef struct packed {
    logic [2:0]  region;
    logic [7:0]  offset;
    logic [31:0] wdata;
    logic [31:0] rexp;   // expected readback
  } reg_row_t;

  typedef struct packed {
    logic [15:0] adc_mul;
    logic [13:0] adc_sum;
    logic [15:0] dac_mul;
    logic [13:0] dac_sum;
    logic        loop;
  } data_row_t;

  localparam int N_RST  = 10;
  localparam int N_REG  = 16;
  localparam int N_DATA = 5;
  localparam int N_PDM  = 3;

  // hk reset values with wdata unused
  localparam reg_row_t RST_TAB [N_RST] = '{
    '{3'd0, rp_pkg::HK_LOOP,     32'h0, 32'h0},
    '{3'd0, rp_pkg::HK_LED,      32'h0, 32'h0},
    '{3'd0, rp_pkg::HK_ADC_MUL0, 32'h0, 32'd16384},
    '{3'd0, rp_pkg::HK_ADC_MUL1, 32'h0, 32'd16384},
    '{3'd0, rp_pkg::HK_ADC_SUM0, 32'h0, 32'h0},
    '{3'd0, rp_pkg::HK_ADC_SUM1, 32'h0, 32'h0},
    '{3'd0, rp_pkg::HK_DAC_MUL0, 32'h0, 32'd16384},
    '{3'd0, rp_pkg::HK_DAC_MUL1, 32'h0, 32'd16384},
    '{3'd0, rp_pkg::HK_DAC_SUM0, 32'h0, 32'h0},
    '{3'd0, rp_pkg::HK_DAC_SUM1, 32'h0, 32'h0}
  };

  localparam reg_row_t REG_TAB [N_REG] = '{
    '{3'd0, rp_pkg::HK_LOOP,     32'h0000_0003, 32'h0000_0001},  // bit 0 only
    '{3'd0, rp_pkg::HK_LED,      32'h0000_01A5, 32'h0000_00A5},
    '{3'd0, rp_pkg::HK_ADC_MUL0, 32'hFFFF_8000, 32'h0000_8000},
    '{3'd0, rp_pkg::HK_ADC_SUM1, 32'h3FFF_ABCD, 32'h0000_2BCD},  // 14 bits kept
    '{3'd0, rp_pkg::HK_DAC_MUL1, 32'h0000_1234, 32'h0000_1234},
    '{3'd0, rp_pkg::HK_DAC_SUM0, 32'h0000_7FFF, 32'h0000_3FFF},
    '{3'd0, rp_pkg::HK_LOOP,     32'h0000_0000, 32'h0000_0000},
    '{3'd0, 8'h40,               32'h0000_0055, 32'h0000_0000},  // hole in hk
    '{3'd4, 8'h08,               32'h0000_01C3, 32'h0000_00C3},  // pdm level 2
    '{3'd4, 8'h40,               32'h0000_0077, 32'h0000_0000},  // hole in ams
    '{3'd1, 8'h00,               32'h0000_DEAD, 32'h0000_0000},
    '{3'd2, 8'h04,               32'h0000_DEAD, 32'h0000_0000},
    '{3'd3, 8'h10,               32'h0000_DEAD, 32'h0000_0000},
    '{3'd5, 8'h00,               32'h0000_DEAD, 32'h0000_0000},
    '{3'd6, 8'h20,               32'h0000_DEAD, 32'h0000_0000},
    '{3'd7, 8'h2C,               32'h0000_DEAD, 32'h0000_0000}
  };

  localparam data_row_t DATA_TAB [N_DATA] = '{
    '{16'h4000, 14'd0,    16'h4000, 14'd0,      1'b0},  // unity
    '{16'h7FFF, 14'd1000, 16'h2000, -14'sd500,  1'b0},  // adc gain ~x2 hits both rails
    '{16'hC000, 14'h2000, 16'h6000, 14'd4000,   1'b0},  // inverting gain with offset -8192
    '{16'h2EE0, 14'd100,  16'h4E20, -14'sd300,  1'b1},  // loopback
    '{16'h4000, 14'd0,    16'h4000, 14'd0,      1'b1}
  };

  localparam logic [7:0] PDM_TAB [N_PDM][rp_pkg::PDM_CHN] = '{
    '{8'd0,   8'd1,   8'd128, 8'd255},
    '{8'd255, 8'd128, 8'd1,   8'd0},
    '{8'd17,  8'd200, 8'd64,  8'd3}
  };

  localparam int WD_CYCLES = 2 * (16 + N_RST * BUS_CYC + N_REG * 2 * BUS_CYC
                                  + N_DATA * (9 * BUS_CYC + N_SAMP)
                                  + N_PDM * (rp_pkg::PDM_CHN * BUS_CYC + 258));

  logic                        adc_clk;
  logic                        frstn;
  rp_pkg::raw_t                adc_dat_i [rp_pkg::CHN];
  rp_pkg::sample_t             asg_dat_i [rp_pkg::CHN];
  rp_pkg::sample_t             pid_dat_i [rp_pkg::CHN];
  rp_pkg::sample_t             adc_dat_o [rp_pkg::CHN];
  rp_pkg::raw_t                dac_dat_o [rp_pkg::CHN];
  logic [rp_pkg::BUS_AW-1:0]   sys_addr_i;
  logic [rp_pkg::BUS_DW-1:0]   sys_wdata_i;
  logic                        sys_wen_i;
  logic                        sys_ren_i;
  logic [rp_pkg::BUS_DW-1:0]   sys_rdata_o;
  logic                        sys_err_o;
  logic                        sys_ack_o;
  logic [rp_pkg::LED_W-1:0]    led_o;
  logic [rp_pkg::PDM_CHN-1:0]  pdm_o;
  int                          errors = 0;

  rp_analog_top uut (
    .adc_clk     (adc_clk),
    .frstn       (frstn),
    .adc_dat_i   (adc_dat_i),
    .asg_dat_i   (asg_dat_i),
    .pid_dat_i   (pid_dat_i),
    .adc_dat_o   (adc_dat_o),
    .dac_dat_o   (dac_dat_o),
    .sys_addr_i  (sys_addr_i),
    .sys_wdata_i (sys_wdata_i),
    .sys_wen_i   (sys_wen_i),
    .sys_ren_i   (sys_ren_i),
    .sys_rdata_o (sys_rdata_o),
    .sys_err_o   (sys_err_o),
    .sys_ack_o   (sys_ack_o),
    .led_o       (led_o),
    .pdm_o       (pdm_o)
  );

  always #(CLK_HALF) adc_clk = ~adc_clk;

  //////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////

  function automatic int clamp(input int v);
    if (v > SMAX)
      return SMAX;
    if (v < SMIN)
      return SMIN;
    return v;
  endfunction

  // pin word is offset binary with negative slope
  function automatic int pin_to_sample(input logic [13:0] raw);
    int v;
    v = int'(raw ^ 14'h1FFF);
    if (v > SMAX)
      v -= 16384;  // upper half is negative
    return v;
  endfunction

  function automatic logic [13:0] sample_to_pin(input int s);
    return 14'(s) ^ 14'h1FFF;
  endfunction

  // gain is 2.14 fixed point and the shift floors
  function automatic int calibrate(input int x, input int mul, input int sum);
    int p;
    p = (x * mul) >>> rp_pkg::CAL_SHIFT;
    return clamp(p + sum);
  endfunction

  function automatic int rand_sample();
    logic signed [13:0] s;
    s = 14'($urandom());
    return s;
  endfunction

  function automatic logic [31:0] reg_addr(input reg_row_t row);
    return (32'(row.region) << rp_pkg::REGION_LSB) | 32'(row.offset);
  endfunction

  //////////////////////////////////////////////////////////////////////
  // bus access and checks
  //////////////////////////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    assert (act === exp)
    else
    begin
      errors++;
      $display("FAILED %s: expected 0x%08h, actual 0x%08h", name, exp, act);
      $display("Simulation finished: FAIL");
      $fatal(1, "mismatch in %s", name);
    end
  endtask

  // one-cycle strobe with the address held until ack
  task automatic bus_access(input logic is_write, input logic [31:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output int latency);
    int waited;
    latency = -1;
    rdata   = '0;
    @(posedge adc_clk);
    #1;
    sys_addr_i  = addr;
    sys_wdata_i = wdata;
    sys_wen_i   = is_write;
    sys_ren_i   = !is_write;
    @(negedge adc_clk);
    if (sys_ack_o)
    begin
      latency = 0;  // combinational answer
      rdata   = sys_rdata_o;
      check_value($sformatf("bus err 0x%08h", addr), 32'h0, {31'h0, sys_err_o});
    end
    @(posedge adc_clk);
    #1;
    sys_wen_i = 1'b0;
    sys_ren_i = 1'b0;
    if (latency != 0)
    begin
      waited = 1;
      while (!sys_ack_o && waited < ACK_TIMEOUT)
      begin
        @(posedge adc_clk);
        #1;
        waited++;
      end
      if (!sys_ack_o)
      begin
        $display("Simulation finished: FAIL");
        $fatal(1, "no bus acknowledge for address 0x%08h after %0d cycles", addr, waited);
      end
      else
      begin
        latency = waited;
        rdata   = sys_rdata_o;
        check_value($sformatf("bus err 0x%08h", addr), 32'h0, {31'h0, sys_err_o});
      end
    end
  endtask

  task automatic hk_write(input logic [7:0] offset, input logic [31:0] data);
    logic [31:0] rd;
    int          lat;
    bus_access(1'b1, {24'h0, offset}, data, rd, lat);
  endtask

  //////////////////////////////////////////////////////////////////////
  // data path and PDM runs
  //////////////////////////////////////////////////////////////////////

  task automatic run_data_row(input int r);
    data_row_t   row;
    int          am, as, dm, ds, dly, g, p, dac_s;
    logic [13:0] raw;
    int          exp_adc [N_SAMP][rp_pkg::CHN];
    logic [13:0] exp_dac [N_SAMP][rp_pkg::CHN];
    row = DATA_TAB[r];
    am  = $signed(row.adc_mul);
    as  = $signed(row.adc_sum);
    dm  = $signed(row.dac_mul);
    ds  = $signed(row.dac_sum);
    dly = row.loop ? 4 : 3;  // loop adds the dac lin_cal stages
    for (int ch = 0; ch < rp_pkg::CHN; ch++)
    begin
      hk_write(rp_pkg::HK_ADC_MUL0 + 8'(4 * ch), {16'h0, row.adc_mul});
      hk_write(rp_pkg::HK_ADC_SUM0 + 8'(4 * ch), {18'h0, row.adc_sum});
      hk_write(rp_pkg::HK_DAC_MUL0 + 8'(4 * ch), {16'h0, row.dac_mul});
      hk_write(rp_pkg::HK_DAC_SUM0 + 8'(4 * ch), {18'h0, row.dac_sum});
    end
    hk_write(rp_pkg::HK_LOOP, {31'h0, row.loop});
    for (int t = 0; t < N_SAMP; t++)
    begin
      @(posedge adc_clk);
      #1;
      for (int ch = 0; ch < rp_pkg::CHN; ch++)
      begin
        case (t % 8)
          0:
          begin
            raw = 14'h0000;  // top rail
            g   = SMAX;
            p   = SMAX;
          end
          1:
          begin
            raw = 14'h3FFF;  // bottom rail
            g   = SMIN;
            p   = SMIN;
          end
          2:
          begin
            raw = 14'h2000;
            g   = SMIN;
            p   = -1;
          end
          default:
          begin
            raw = 14'($urandom());
            g   = rand_sample();
            p   = rand_sample();
          end
        endcase
        adc_dat_i[ch] = raw;
        asg_dat_i[ch] = 14'(g);
        pid_dat_i[ch] = 14'(p);
        dac_s = calibrate(clamp(g + p), dm, ds);
        exp_dac[t][ch] = sample_to_pin(dac_s);
        exp_adc[t][ch] = calibrate(row.loop ? dac_s : pin_to_sample(raw), am, as);
      end
      @(negedge adc_clk);
      if (t >= 4)  // pipeline filled with this row
      begin
        for (int ch = 0; ch < rp_pkg::CHN; ch++)
        begin
          check_value($sformatf("row%0d adc ch%0d t%0d", r, ch, t),
                      {18'h0, 14'(exp_adc[t - dly][ch])}, {18'h0, adc_dat_o[ch]});
          check_value($sformatf("row%0d dac ch%0d t%0d", r, ch, t),
                      {18'h0, exp_dac[t - 3][ch]}, {18'h0, dac_dat_o[ch]});
        end
      end
    end
  endtask

  task automatic run_pdm_row(input int r);
    int          ones [rp_pkg::PDM_CHN];
    logic [31:0] rd;
    int          lat;
    for (int ch = 0; ch < rp_pkg::PDM_CHN; ch++)
    begin
      bus_access(1'b1, (32'(rp_pkg::REG_AMS) << rp_pkg::REGION_LSB) | 32'(4 * ch),
                 {24'h0, PDM_TAB[r][ch]}, rd, lat);
      ones[ch] = 0;
    end
    @(posedge adc_clk);  // first carry from the new level
    repeat (256)
    begin
      @(negedge adc_clk);
      for (int ch = 0; ch < rp_pkg::PDM_CHN; ch++)
        ones[ch] += int'(pdm_o[ch]);
    end
    for (int ch = 0; ch < rp_pkg::PDM_CHN; ch++)
      check_value($sformatf("pdm row%0d ch%0d ones", r, ch),
                  {24'h0, PDM_TAB[r][ch]}, 32'(ones[ch]));
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    #(WD_CYCLES * 2 * CLK_HALF);
    $display("Simulation finished: FAIL");
    $fatal(1, "watchdog expired after %0d cycles", WD_CYCLES);
  end

  initial
  begin
    logic [31:0] rd;
    int          lat;
    logic        live;
    void'($urandom(SEED));
    adc_clk     = 1'b0;
    frstn       = 1'b0;
    sys_addr_i  = '0;
    sys_wdata_i = '0;
    sys_wen_i   = 1'b0;
    sys_ren_i   = 1'b0;
    for (int ch = 0; ch < rp_pkg::CHN; ch++)
    begin
      adc_dat_i[ch] = '0;
      asg_dat_i[ch] = '0;
      pid_dat_i[ch] = '0;
    end
    repeat (3) @(posedge adc_clk);
    #1;
    frstn = 1'b1;

    check_value("reset led_o", 32'h0, {24'h0, led_o});
    check_value("reset pdm_o", 32'h0, {28'h0, pdm_o});
    for (int i = 0; i < N_RST; i++)
    begin
      bus_access(1'b0, reg_addr(RST_TAB[i]), 32'h0, rd, lat);
      check_value($sformatf("reset hk 0x%02h", RST_TAB[i].offset), RST_TAB[i].rexp, rd);
    end

    // write and read back, then ack timing per region
    for (int i = 0; i < N_REG; i++)
    begin
      live = (REG_TAB[i].region == 3'd0) || (REG_TAB[i].region == 3'd4);
      bus_access(1'b1, reg_addr(REG_TAB[i]), REG_TAB[i].wdata, rd, lat);
      bus_access(1'b0, reg_addr(REG_TAB[i]), 32'h0, rd, lat);
      check_value($sformatf("reg row%0d readback", i), REG_TAB[i].rexp, rd);
      check_value($sformatf("reg row%0d ack latency", i), live ? 32'd1 : 32'd0, 32'(lat));
      if (REG_TAB[i].region == 3'd0 && REG_TAB[i].offset == rp_pkg::HK_LED)
        check_value("led_o follows hk", REG_TAB[i].rexp, {24'h0, led_o});
    end

    for (int r = 0; r < N_DATA; r++)
      run_data_row(r);
    for (int r = 0; r < N_PDM; r++)
      run_pdm_row(r);

    if (errors == 0)
    begin
      $display("Simulation finished: PASS");
      $finish;
    end
    else
    begin
      $display("Simulation finished: FAIL");
      $fatal(1, "%0d checks failed", errors);
    end
  end

endmodule

// ==== filelist.f ====
design/rp_pkg.sv
design/sys_bus_decoder.sv
design/hk_regs.sv
design/lin_cal.sv
design/analog_path.sv
design/ams_pdm.sv
design/rp_analog_top.sv
dv/rp_analog_properties.sv
dv/tb_rp_analog.sv

// ==== Makefile ====
# Verilator build and run of the analog front end testbench

VERILATOR ?= verilator
TOP       ?= tb_rp_analog
SEED      ?= 4856
BUILD_DIR ?= obj_dir
FILELIST  ?= filelist.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -GSEED=$(SEED) \
	  --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
